// ==== Bender.yml ====
package:
  name: hwlp

sources:
  # packages first, then the RTL
  - files:
      - hw/hwlp_pkg.sv
      - hw/seq_pkg.sv
      - hw/hwlp_regs.sv
      - hw/hwlp_ctrl.sv
      - hw/pc_seq.sv
      - hw/hwlp_top.sv

  - target: test
    files:
      - test/tb_hwlp.sv

// ==== filelist.f ====
hw/hwlp_pkg.sv
hw/seq_pkg.sv
hw/hwlp_regs.sv
hw/hwlp_ctrl.sv
hw/pc_seq.sv
hw/hwlp_top.sv
test/tb_hwlp.sv

// ==== hw/hwlp_ctrl.sv ====
`default_nettype none

module hwlp_ctrl
  import hwlp_pkg::*;
  import seq_pkg::*;
(
  // current pc and retire strobe from the sequencer
  input  wire pc_t                    pc_i,
  input  wire logic                   retire_i,

  // loop register sets
  input  wire hwlp_set_t [N_HWLP-1:0] loops_i,

  // counter decrement, onehot or zero
  output      logic      [N_HWLP-1:0] dec_o,

  // jump back to a loop start
  output      redirect_t              redirect_o
);

  // per-loop end-address hit on an active loop
  logic      [N_HWLP-1:0] match;
  logic                   found;
  hwlp_id_t               sel;
  hwlp_set_t              sel_loop;

  ////////////////////////////////////////////////////////////
  // end-address match
  ////////////////////////////////////////////////////////////

  always_comb
  begin : match_logic
    for (int i = 0; i < N_HWLP; i++)
    begin
      // a loop counts as active while its counter is nonzero
      match[i] = (loops_i[i].cnt != '0) && (loops_i[i].end_addr == pc_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // priority select, lowest index wins
  ////////////////////////////////////////////////////////////

  always_comb
  begin : prio_sel
    found = 1'b0;
    sel   = '0;
    // walk from the top so the last hit is the lowest index
    for (int i = N_HWLP - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        found = 1'b1;
        sel   = hwlp_id_t'(i);
      end
    end
  end

  assign sel_loop = loops_i[sel];

  ////////////////////////////////////////////////////////////
  // decrement strobe and redirect
  ////////////////////////////////////////////////////////////

  always_comb
  begin : dec_logic
    dec_o = '0;
    // only one bit can be set since sel is a single id
    if (retire_i && found)
    begin
      dec_o[sel] = 1'b1;
    end
  end

  always_comb
  begin : redirect_logic
    // last iteration falls through to pc + 4
    redirect_o.taken  = retire_i && found && (sel_loop.cnt > cnt_t'(1));
    redirect_o.target = sel_loop.start_addr;
  end

endmodule

`default_nettype wire

// ==== hw/hwlp_pkg.sv ====
`default_nettype none

package hwlp_pkg;

  ////////////////////////////////////////////////////////////
  // loop count and id width
  ////////////////////////////////////////////////////////////

  // loop 0 is the inner loop and wins on a shared end address
  localparam int unsigned N_HWLP    = 2;
  localparam int unsigned HWLP_ID_W = 1;

  // bit positions inside the write-enable vector
  localparam int unsigned WE_START = 0;
  localparam int unsigned WE_END   = 1;
  localparam int unsigned WE_CNT   = 2;

  ////////////////////////////////////////////////////////////
  // basic vector types
  ////////////////////////////////////////////////////////////

  // byte address, always word aligned here
  typedef logic [31:0]          addr_t;
  // remaining iterations, zero means inactive
  typedef logic [31:0]          cnt_t;
  typedef logic [HWLP_ID_W-1:0] hwlp_id_t;

  // write request as driven by the execute stage
  typedef struct packed {
    logic [2:0] we;
    hwlp_id_t   id;
    addr_t      start_addr;
    addr_t      end_addr;
    cnt_t       cnt;
  } hwlp_wreq_t;

  // one loop's register set
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
    cnt_t  cnt;
  } hwlp_set_t;

endpackage

`default_nettype wire

// ==== hw/hwlp_regs.sv ====
`default_nettype none

module hwlp_regs
  import hwlp_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // write port from the execute stage
  input  wire hwlp_wreq_t             wreq_i,

  // decrement strobes already qualified by retire
  input  wire logic      [N_HWLP-1:0] dec_i,

  // register sets to the controller and the outside
  output      hwlp_set_t [N_HWLP-1:0] loops_o
);

  hwlp_set_t [N_HWLP-1:0] loops_q;

  assign loops_o = loops_q;

  ////////////////////////////////////////////////////////////
  // start, end and counter registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : loop_regs
    if (!rst_n)
    begin
      loops_q <= '0;
    end
    else
    begin
      for (int i = 0; i < N_HWLP; i++)
      begin
        // only the loop picked by id takes the write
        if (wreq_i.we[WE_START] && (wreq_i.id == hwlp_id_t'(i)))
        begin
          loops_q[i].start_addr <= wreq_i.start_addr;
        end
        if (wreq_i.we[WE_END] && (wreq_i.id == hwlp_id_t'(i)))
        begin
          loops_q[i].end_addr <= wreq_i.end_addr;
        end
        // a count write beats a decrement on the same edge
        if (wreq_i.we[WE_CNT] && (wreq_i.id == hwlp_id_t'(i)))
        begin
          loops_q[i].cnt <= wreq_i.cnt;
        end
        else if (dec_i[i])
        begin
          loops_q[i].cnt <= loops_q[i].cnt - cnt_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/hwlp_top.sv ====
`default_nettype none

module hwlp_top
  import hwlp_pkg::*;
  import seq_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // loop register write port
  input  wire hwlp_wreq_t             wreq_i,

  // run control
  input  wire logic                   start_i,
  input  wire pc_t                    boot_addr_i,
  input  wire pc_t                    stop_addr_i,
  input  wire logic                   step_i,

  output      pc_t                    pc_o,
  output      logic                   running_o,
  output      logic                   done_o,
  // counters exposed for observation
  output      hwlp_set_t [N_HWLP-1:0] loops_o
);

  logic [N_HWLP-1:0] dec;
  redirect_t         redirect;
  logic              retire;

  ////////////////////////////////////////////////////////////
  // loop registers and controller
  ////////////////////////////////////////////////////////////

  hwlp_regs i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wreq_i  (wreq_i),
    .dec_i   (dec),
    .loops_o (loops_o)
  );

  hwlp_ctrl i_ctrl (
    .pc_i       (pc_o),
    .retire_i   (retire),
    .loops_i    (loops_o),
    .dec_o      (dec),
    .redirect_o (redirect)
  );

  // pc sequencer
  pc_seq i_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .boot_addr_i (boot_addr_i),
    .stop_addr_i (stop_addr_i),
    .step_i      (step_i),
    .redirect_i  (redirect),
    .pc_o        (pc_o),
    .retire_o    (retire),
    .running_o   (running_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

// ==== hw/pc_seq.sv ====
`default_nettype none

module pc_seq
  import seq_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // run control
  input  wire logic      start_i,
  input  wire pc_t       boot_addr_i,
  input  wire pc_t       stop_addr_i,
  input  wire logic      step_i,

  // loop redirect from the controller
  input  wire redirect_t redirect_i,

  output      pc_t       pc_o,
  output      logic      retire_o,
  output      logic      running_o,
  output      logic      done_o
);

  seq_state_e state_q, state_d;
  pc_t        pc_q, pc_d;
  // stop address captured with start
  pc_t        stop_q;
  logic       at_stop;

  ////////////////////////////////////////////////////////////
  // retire and stop detection
  ////////////////////////////////////////////////////////////

  // a step only counts while running
  assign retire_o = step_i && (state_q == SEQ_RUN);

  // stop check sits behind the redirect so a loop ending
  // on the stop address finishes its iterations first
  assign at_stop = (pc_q == stop_q) && !redirect_i.taken;

  ////////////////////////////////////////////////////////////
  // next-state logic
  ////////////////////////////////////////////////////////////

  always_comb
  begin : next_state
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      SEQ_IDLE:
      begin
        if (start_i)
        begin
          state_d = SEQ_RUN;
          pc_d    = boot_addr_i;
        end
      end
      SEQ_RUN:
      begin
        if (retire_o)
        begin
          if (at_stop)
            state_d = SEQ_DONE;
          else if (redirect_i.taken)
            pc_d = redirect_i.target;
          else
            pc_d = pc_q + PC_STEP;
        end
      end
      SEQ_DONE:
      begin
        // back to idle so a further start launches the next run
        if (start_i)
          state_d = SEQ_IDLE;
      end
      default:
      begin
        state_d = SEQ_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin : state_regs
    if (!rst_n)
    begin
      state_q <= SEQ_IDLE;
      pc_q    <= '0;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin : stop_reg
    if (!rst_n)
      stop_q <= '0;
    else if (start_i && (state_q == SEQ_IDLE))
      stop_q <= stop_addr_i;
  end

  assign pc_o      = pc_q;
  assign running_o = (state_q == SEQ_RUN);
  assign done_o    = (state_q == SEQ_DONE);

endmodule

`default_nettype wire

// ==== hw/seq_pkg.sv ====
`default_nettype none

package seq_pkg;

  import hwlp_pkg::addr_t;

  ////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////

  // same width as a loop address so the two compare directly
  typedef logic [$bits(addr_t)-1:0] pc_t;

  // sequential increment, one 32-bit instruction
  localparam pc_t PC_STEP = 32'd4;

  ////////////////////////////////////////////////////////////
  // sequencer FSM and redirect
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_RUN  = 2'd1,
    SEQ_DONE = 2'd2
  } seq_state_e;

  // loop redirect from the controller
  typedef struct packed {
    logic taken;
    pc_t  target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== test/tb_hwlp.sv ====
`default_nettype none

module tb_hwlp
  import hwlp_pkg::*;
  import seq_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int MARGIN     = 50 * CLK_PERIOD;
  localparam int N_RANDOM   = 8;

  logic                   clk;
  logic                   rst_n;
  hwlp_wreq_t             wreq;
  logic                   start;
  pc_t                    boot_addr;
  pc_t                    stop_addr;
  logic                   step;
  pc_t                    pc;
  logic                   running;
  logic                   done;
  hwlp_set_t [N_HWLP-1:0] loops;

  // expected trace of the current run and the retires seen so far
  addr_t    exp_q[$];
  int       ret_cnt;
  string    test_name;
  int       n_mismatch;
  int       n_other;
  longint   deadline;
  int       seed;

  // count write issued on a retire at rearm_pc up to rearm_max times
  addr_t    rearm_pc;
  hwlp_id_t rearm_id;
  cnt_t     rearm_cnt;
  int       rearm_max;
  int       rearms_done;

  hwlp_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wreq_i      (wreq),
    .start_i     (start),
    .boot_addr_i (boot_addr),
    .stop_addr_i (stop_addr),
    .step_i      (step),
    .pc_o        (pc),
    .running_o   (running),
    .done_o      (done),
    .loops_o     (loops)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // walks the loop rules and fills exp_q with the retired pcs
  function automatic int trace_model(hwlp_set_t p0, hwlp_set_t p1, addr_t boot, addr_t stop);
    cnt_t  c0;
    cnt_t  c1;
    addr_t cur;
    addr_t nxt;
    logic  taken;
    int    n_rearm;
    c0 = p0.cnt;
    c1 = p1.cnt;
    cur = boot;
    n_rearm = 0;
    exp_q.delete();
    while (exp_q.size() < 4096)
    begin
      exp_q.push_back(cur);
      taken = 1'b0;
      nxt = cur + 32'd4;
      // inner loop first and outer only when the inner does not hit
      if ((c0 != 0) && (p0.end_addr == cur))
      begin
        taken = (c0 > 1);
        if (taken)
          nxt = p0.start_addr;
        c0 = c0 - 1;
      end
      else if ((c1 != 0) && (p1.end_addr == cur))
      begin
        taken = (c1 > 1);
        if (taken)
          nxt = p1.start_addr;
        c1 = c1 - 1;
      end
      // a count write lands on top of any decrement
      if ((cur == rearm_pc) && (n_rearm < rearm_max))
      begin
        if (rearm_id == 0)
          c0 = rearm_cnt;
        else
          c1 = rearm_cnt;
        n_rearm++;
      end
      if ((cur == stop) && !taken)
        break;
      cur = nxt;
    end
    return exp_q.size();
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic expect_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
      n_mismatch++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // comparing process
  ////////////////////////////////////////////////////////////

  // a retire is step high while the FSM is in run
  always @(posedge clk)
  begin : compare_retire
    if (rst_n && running && step)
    begin
      if (ret_cnt < exp_q.size())
      begin
        assert (pc == exp_q[ret_cnt])
        else
        begin
          $display("mismatch %s retire %0d expected %h actual %h",
                   test_name, ret_cnt, exp_q[ret_cnt], pc);
          n_mismatch++;
        end
      end
      else
      begin
        $display("%s: the DUT retired more pcs than the model expects", test_name);
        n_other++;
      end
      ret_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic write_loop(hwlp_id_t id, hwlp_set_t p);
    wreq.we         = 3'b111;
    wreq.id         = id;
    wreq.start_addr = p.start_addr;
    wreq.end_addr   = p.end_addr;
    wreq.cnt        = p.cnt;
    @(posedge clk);
    #2;
    wreq = '0;
  endtask

  task automatic run_test(string name, hwlp_set_t p0, hwlp_set_t p1, addr_t boot, addr_t stop);
    int   len;
    logic wrote;
    test_name = name;
    len = trace_model(p0, p1, boot, stop);
    ret_cnt = 0;
    rearms_done = 0;
    // random gaps in step need roughly four cycles per retire
    deadline = $time + CLK_PERIOD * 4 * len + MARGIN;
    write_loop(0, p0);
    write_loop(1, p1);
    start = 1'b1;
    boot_addr = boot;
    stop_addr = stop;
    @(posedge clk);
    #2;
    start = 1'b0;
    expect_value("running", 1'b1, running);
    while (!done)
    begin
      step = (rand_range(0, 3) != 0);
      wreq = '0;
      wrote = 1'b0;
      // count write in the same cycle as the retire at rearm_pc
      if (step && running && (pc == rearm_pc) && (rearms_done < rearm_max))
      begin
        wreq.we[WE_CNT] = 1'b1;
        wreq.id = rearm_id;
        wreq.cnt = rearm_cnt;
        rearms_done++;
        wrote = 1'b1;
      end
      @(posedge clk);
      #2;
      wreq = '0;
      if (wrote)
        expect_value("written count", rearm_cnt, loops[rearm_id].cnt);
    end
    step = 1'b0;
    expect_value("running", '0, running);
    assert (ret_cnt == len)
    else
    begin
      if (ret_cnt < len)
        $display("%s: run ended early after %0d of %0d pcs", name, ret_cnt, len);
      else
        $display("%s: run ended late after %0d of %0d pcs", name, ret_cnt, len);
      n_other++;
    end
    // done back to idle
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    expect_value("done", '0, done);
    rearm_max = 0;
  endtask

  function automatic hwlp_set_t mk_loop(addr_t s, addr_t e, cnt_t c);
    hwlp_set_t p;
    p.start_addr = s;
    p.end_addr   = e;
    p.cnt        = c;
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin : main
    hwlp_set_t p0;
    hwlp_set_t p1;
    addr_t     base;
    clk = 1'b0;
    rst_n = 1'b0;
    wreq = '0;
    start = 1'b0;
    boot_addr = '0;
    stop_addr = '0;
    step = 1'b0;
    seed = 32'hfdd1;
    n_mismatch = 0;
    n_other = 0;
    ret_cnt = 0;
    rearm_max = 0;
    rearm_pc = '0;
    rearm_id = '0;
    rearm_cnt = '0;
    deadline = 20 * CLK_PERIOD;
    test_name = "reset";
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // everything idle and cleared after reset
    for (int i = 0; i < N_HWLP; i++)
    begin
      expect_value("start", '0, loops[i].start_addr);
      expect_value("end", '0, loops[i].end_addr);
      expect_value("count", '0, loops[i].cnt);
    end
    expect_value("running", '0, running);
    expect_value("done", '0, done);
    run_test("reset", '0, '0, 32'h100, 32'h120);

    run_test("single", '0, mk_loop(32'h204, 32'h20c, 3), 32'h200, 32'h214);
    expect_value("loop1 count", '0, loops[1].cnt);

    // inner count reloaded at the top of each outer body
    rearm_pc = 32'h308;
    rearm_id = 0;
    rearm_cnt = 2;
    rearm_max = 1000;
    run_test("nested", mk_loop(32'h30c, 32'h314, 2), mk_loop(32'h304, 32'h320, 3),
             32'h300, 32'h324);

    run_test("count_one", mk_loop(32'h504, 32'h508, 1), '0, 32'h500, 32'h50c);
    expect_value("loop0 count", '0, loops[0].cnt);

    run_test("shared_end", mk_loop(32'h404, 32'h40c, 2), mk_loop(32'h400, 32'h40c, 2),
             32'h400, 32'h410);
    expect_value("loop0 count", '0, loops[0].cnt);
    expect_value("loop1 count", 32'd2, loops[1].cnt);

    // count write collides with the decrement at the loop end
    rearm_pc = 32'h60c;
    rearm_id = 1;
    rearm_cnt = 3;
    rearm_max = 1;
    run_test("write_prio", '0, mk_loop(32'h604, 32'h60c, 2), 32'h600, 32'h610);

    for (int t = 0; t < N_RANDOM; t++)
    begin
      base = 32'h1000 * (t + 1);
      p0.start_addr = base + 4 * rand_range(2, 3);
      p0.end_addr = p0.start_addr + 4 * rand_range(0, 3);
      p0.cnt = rand_range(1, 5);
      p1.start_addr = base + 4;
      p1.end_addr = p0.end_addr + 4 * rand_range(0, 3);
      p1.cnt = rand_range(1, 5);
      rearm_pc = p1.start_addr;
      rearm_id = 0;
      rearm_cnt = p0.cnt;
      rearm_max = 1000;
      run_test($sformatf("random_%0d", t), p0, p1, base,
               p1.end_addr + 4 * rand_range(1, 2));
    end

    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if ((n_mismatch + n_other) == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // deadline moves forward with each run
  initial
  begin : watchdog
    #1;
    while ($time <= deadline)
      @(posedge clk);
    $display("timeout: %s did not reach done in time", test_name);
    n_other++;
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
